//--- fir_sym_top.f
verilog/fir_pkg.sv
verilog/fold_delay_line.sv
verilog/coef_bank.sv
verilog/symmetric_mac.sv
verilog/fir_sym_top.sv
bench/fir_sym_asserts.sv
bench/fir_sym_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the FIR testbench, the log decides pass or fail.
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing --assert --top-module fir_sym_tb \
  -f fir_sym_top.f -Mdir obj_dir -o fir_sym_sim &&
./obj_dir/fir_sym_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log 2>/dev/null && exit 0 || exit 1

//--- bench/fir_sym_tb.sv
`timescale 1ns/100ps
`default_nettype none

module fir_sym_tb;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 5;
  localparam logic [31:0] SEED         = 32'hbb122343;
  localparam int          NUM_RANDOM   = 200;
  localparam int          NUM_FULL     = 40;
  localparam int          NUM_RELOAD   = 20;
  localparam int          DRAIN_LIMIT  = 20;

  // at most two cycles per random sample, plus coefficient writes and six drains.
  localparam int STIM_CYCLES = RESET_CYCLES + 2 + 2 * NUM_RANDOM + NUM_FULL + NUM_RELOAD
                             + 3 * fir_pkg::NUM_TAPS + 3 * fir_pkg::NUM_COEF
                             + 6 * (DRAIN_LIMIT + 1);
  localparam int MARGIN_CYCLES = 100;
  localparam int WATCHDOG_NS   = (STIM_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  // every tap and every coefficient at full scale.
  localparam logic [63:0] FULL_SCALE = 64'(fir_pkg::NUM_TAPS)
                                     * ((64'd1 << fir_pkg::SAMPLE_W) - 64'd1)
                                     * ((64'd1 << fir_pkg::COEF_W) - 64'd1);

  logic                clk = 1'b0;
  logic                rst_n;
  logic                in_valid;
  fir_pkg::sample_t    in_data;
  logic                coef_wr;
  fir_pkg::coef_addr_t coef_addr;
  fir_pkg::coef_t      coef_data;
  logic                out_valid;
  fir_pkg::acc_t       out_data;

  // model state, newest sample at index 0.
  fir_pkg::sample_t hist [fir_pkg::NUM_TAPS];
  fir_pkg::coef_t   model_coefs [fir_pkg::NUM_COEF];

  fir_pkg::acc_t exp_q [$];
  int            in_cycle_q [$];  // edge that sampled each in_valid.

  int cycle        = 0;
  int out_count    = 0;
  int value_errors = 0;
  int other_errors = 0;

  always #(CLK_PERIOD / 2) clk = ~clk;

  always @(posedge clk) cycle <= cycle + 1;

  fir_sym_top i_fir_sym_top (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .coef_wr   (coef_wr),
    .coef_addr (coef_addr),
    .coef_data (coef_data),
    .out_valid (out_valid),
    .out_data  (out_data)
  );

  // direct form of the symmetric filter over the model history.
  function automatic fir_pkg::acc_t ref_output();
    fir_pkg::acc_t sum;
    sum = '0;
    for (int k = 0; k < fir_pkg::NUM_PAIRS; k++) begin
      sum = sum + fir_pkg::acc_t'(model_coefs[k])
                * (fir_pkg::acc_t'(hist[k]) + fir_pkg::acc_t'(hist[fir_pkg::NUM_TAPS-1-k]));
    end
    sum = sum + fir_pkg::acc_t'(model_coefs[fir_pkg::NUM_PAIRS])
              * fir_pkg::acc_t'(hist[fir_pkg::NUM_PAIRS]);
    return sum;
  endfunction

  task automatic check_acc(input string name, input fir_pkg::acc_t got,
                           input fir_pkg::acc_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      value_errors++;
    end
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
    coef_wr  = 1'b0;
  endtask

  task automatic shift_history(input fir_pkg::sample_t s);
    for (int k = fir_pkg::NUM_TAPS - 1; k > 0; k--) begin
      hist[k] = hist[k-1];
    end
    hist[0] = s;
  endtask

  task automatic drive_sample(input fir_pkg::sample_t s, input fir_pkg::acc_t exp);
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = s;
    coef_wr  = 1'b0;
    exp_q.push_back(exp);
    in_cycle_q.push_back(cycle + 1);
  endtask

  task automatic send_sample(input fir_pkg::sample_t s);
    shift_history(s);
    drive_sample(s, ref_output());
  endtask

  task automatic write_coef(input fir_pkg::coef_addr_t addr, input fir_pkg::coef_t data);
    @(negedge clk);
    in_valid  = 1'b0;
    coef_wr   = 1'b1;
    coef_addr = addr;
    coef_data = data;
    model_coefs[addr] = data;
  endtask

  // waits until every pending result came out.
  task automatic drain();
    int waited;
    waited = 0;
    idle_cycle();
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      idle_cycle();
      waited++;
    end
    if (exp_q.size() != 0) begin
      $display("pipeline did not drain, %0d results never came out", exp_q.size());
      other_errors++;
      exp_q.delete();
      in_cycle_q.delete();
    end
  endtask

  always @(negedge clk) begin
    int latency;
    if (rst_n === 1'b1 && out_valid === 1'b1) begin
      out_count++;
      if (exp_q.size() == 0) begin
        $display("out_valid was high at cycle %0d with no sample pending", cycle);
        other_errors++;
      end else begin
        check_acc("out_data", out_data, exp_q.pop_front());
        latency = cycle - in_cycle_q.pop_front();
        if (latency != fir_pkg::LATENCY) begin
          $display("out_valid came %0d cycles after in_valid instead of %0d",
                   latency, fir_pkg::LATENCY);
          other_errors++;
        end
      end
    end
  end

  initial begin
    int base;
    int pos;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_data   = '0;
    coef_wr   = 1'b0;
    coef_addr = '0;
    coef_data = '0;
    for (int k = 0; k < fir_pkg::NUM_TAPS; k++) hist[k] = '0;
    for (int k = 0; k < fir_pkg::NUM_COEF; k++) model_coefs[k] = '0;
    void'($urandom(SEED));

    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      check_acc("out_data", out_data, '0);
    end
    rst_n = 1'b1;
    repeat (2) begin
      idle_cycle();
      check_bit("out_valid", out_valid, 1'b0);
      check_acc("out_data", out_data, '0);
    end

    // impulse, the taps read back as the coefficient sequence.
    for (int k = 0; k < fir_pkg::NUM_COEF; k++) begin
      write_coef(fir_pkg::coef_addr_t'(k), fir_pkg::coef_t'(16'h1000 + 16'h0111 * k));
    end
    for (int i = 0; i < fir_pkg::NUM_TAPS; i++) begin
      pos = (i < fir_pkg::NUM_COEF) ? i : fir_pkg::NUM_TAPS - 1 - i;
      shift_history((i == 0) ? fir_pkg::sample_t'(1) : '0);
      drive_sample(hist[0], fir_pkg::acc_t'(model_coefs[pos]));
    end
    drain();

    base = out_count;
    for (int n = 0; n < NUM_RANDOM; n++) begin
      if ($urandom % 2 == 0) idle_cycle();  // random gap.
      send_sample(fir_pkg::sample_t'($urandom));
    end
    drain();
    if (out_count - base != NUM_RANDOM) begin
      $display("random stream gave %0d outputs for %0d samples", out_count - base, NUM_RANDOM);
      other_errors++;
    end

    for (int n = 0; n < NUM_FULL; n++) begin
      send_sample(fir_pkg::sample_t'($urandom));
    end
    drain();

    // reload while the old samples stay in the line.
    write_coef(fir_pkg::coef_addr_t'(0), 16'h7a31);
    write_coef(fir_pkg::coef_addr_t'(3), 16'h0c5e);
    write_coef(fir_pkg::coef_addr_t'(7), 16'hd00d);
    for (int n = 0; n < NUM_RELOAD; n++) begin
      send_sample(fir_pkg::sample_t'($urandom));
    end
    drain();

    for (int k = 0; k < fir_pkg::NUM_COEF; k++) begin
      write_coef(fir_pkg::coef_addr_t'(k), '1);
    end
    for (int n = 0; n < fir_pkg::NUM_TAPS; n++) begin
      send_sample('1);
    end
    drain();
    check_acc("out_data", out_data, fir_pkg::acc_t'(FULL_SCALE));

    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- bench/fir_sym_asserts.sv
`timescale 1ns/100ps
`default_nettype none

module fir_sym_asserts (
  input logic clk,
  input logic rst_n,
  input logic in_valid,
  input logic out_valid
);

  // set on the first edge in reset, out_valid is cleared from then on.
  logic reset_seen = 1'b0;

  always @(posedge clk) begin
    if (!rst_n) reset_seen <= 1'b1;
  end

  // out_valid is registered LATENCY edges after the edge that takes in_valid and sampled one later.
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(in_valid, fir_pkg::LATENCY + 1) |-> out_valid)
    else $error("out_valid missing %0d cycles after in_valid", fir_pkg::LATENCY);

  a_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> $past(in_valid, fir_pkg::LATENCY + 1))
    else $error("out_valid without a matching in_valid");

  a_reset: assert property (@(posedge clk) (!rst_n && reset_seen) |-> !out_valid)
    else $error("out_valid high during reset");

  a_known: assert property (@(posedge clk) disable iff (!rst_n) !$isunknown(out_valid))
    else $error("out_valid unknown after reset");

endmodule

bind fir_sym_top fir_sym_asserts i_fir_sym_asserts (
  .clk       (clk),
  .rst_n     (rst_n),
  .in_valid  (in_valid),
  .out_valid (out_valid)
);

`default_nettype wire

//--- verilog/fir_sym_top.sv
`timescale 1ns/100ps
`default_nettype none

module fir_sym_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 in_valid,
  input  fir_pkg::sample_t     in_data,
  input  logic                 coef_wr,
  input  fir_pkg::coef_addr_t  coef_addr,
  input  fir_pkg::coef_t       coef_data,
  output logic                 out_valid,
  output fir_pkg::acc_t        out_data
);

  // delay line to MAC.
  logic           pair_valid;
  fir_pkg::pair_t pair_sums [fir_pkg::NUM_COEF];

  // coefficient bank to MAC, static between writes.
  fir_pkg::coef_t coefs [fir_pkg::NUM_COEF];

  fold_delay_line i_fold_delay_line (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .pair_valid (pair_valid),
    .pair_sums  (pair_sums)
  );

  coef_bank i_coef_bank (
    .clk       (clk),
    .rst_n     (rst_n),
    .coef_wr   (coef_wr),
    .coef_addr (coef_addr),
    .coef_data (coef_data),
    .coefs     (coefs)
  );

  // two pipeline stages after the pre-adder.
  symmetric_mac i_symmetric_mac (
    .clk        (clk),
    .rst_n      (rst_n),
    .pair_valid (pair_valid),
    .pair_sums  (pair_sums),
    .coefs      (coefs),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

endmodule

`default_nettype wire

//--- verilog/symmetric_mac.sv
`timescale 1ns/100ps
`default_nettype none

module symmetric_mac (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            pair_valid,
  input  fir_pkg::pair_t  pair_sums [fir_pkg::NUM_COEF],
  input  fir_pkg::coef_t  coefs [fir_pkg::NUM_COEF],
  output logic            out_valid,
  output fir_pkg::acc_t   out_data
);

  fir_pkg::prod_t prods [fir_pkg::NUM_COEF];
  logic           prod_valid;

  // sum of the registered products, feeds the output register.
  fir_pkg::acc_t  prod_sum;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prod_valid <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      prod_valid <= pair_valid;
      out_valid  <= prod_valid;
    end
  end

  // stage one, one multiplier per coefficient.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < fir_pkg::NUM_COEF; k++) begin
        prods[k] <= '0;
      end
    end else if (pair_valid) begin
      for (int k = 0; k < fir_pkg::NUM_COEF; k++) begin
        prods[k] <= fir_pkg::prod_t'(pair_sums[k]) * fir_pkg::prod_t'(coefs[k]);
      end
    end
  end

  // each product is below 2**37, so eight of them fit in 40 bits.
  always_comb begin
    prod_sum = '0;
    for (int k = 0; k < fir_pkg::NUM_COEF; k++) begin
      prod_sum = prod_sum + fir_pkg::acc_t'(prods[k]);
    end
  end

  // stage two, full width result, no rounding.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_data <= '0;
    end else if (prod_valid) begin
      out_data <= prod_sum;  // held until the next result.
    end
  end

endmodule

`default_nettype wire

//--- verilog/coef_bank.sv
`timescale 1ns/100ps
`default_nettype none

module coef_bank (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 coef_wr,
  input  fir_pkg::coef_addr_t  coef_addr,
  input  fir_pkg::coef_t       coef_data,
  output fir_pkg::coef_t       coefs [fir_pkg::NUM_COEF]
);

  // one-hot write enables, one per coefficient register.
  logic [fir_pkg::NUM_COEF-1:0] wr_sel;

  for (genvar k = 0; k < fir_pkg::NUM_COEF; k++) begin : g_coef

    assign wr_sel[k] = coef_wr && (coef_addr == fir_pkg::coef_addr_t'(k));

    // value is visible to the MAC from the cycle after the write.
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        coefs[k] <= '0;  // a cleared bank gives a zero output.
      end else if (wr_sel[k]) begin
        coefs[k] <= coef_data;
      end
    end

  end

endmodule

`default_nettype wire

//--- verilog/fold_delay_line.sv
`timescale 1ns/100ps
`default_nettype none

module fold_delay_line (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  fir_pkg::sample_t  in_data,
  output logic              pair_valid,
  output fir_pkg::pair_t    pair_sums [fir_pkg::NUM_COEF]
);

  // tap 0 holds the newest sample, tap 14 the oldest.
  fir_pkg::sample_t taps [fir_pkg::NUM_TAPS];

  // high for one cycle after the taps moved.
  logic shifted;

  // the line only moves on a strobe, so samples survive gaps in the stream.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < fir_pkg::NUM_TAPS; k++) begin
        taps[k] <= '0;
      end
    end else if (in_valid) begin
      taps[0] <= in_data;
      for (int k = 1; k < fir_pkg::NUM_TAPS; k++) begin
        taps[k] <= taps[k-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      shifted    <= 1'b0;
      pair_valid <= 1'b0;
    end else begin
      shifted    <= in_valid;
      pair_valid <= shifted;  // sums below land on the same edge.
    end
  end

  // pre-adder, folds tap k with its mirror tap 14-k.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < fir_pkg::NUM_COEF; k++) begin
        pair_sums[k] <= '0;
      end
    end else if (shifted) begin
      for (int k = 0; k < fir_pkg::NUM_PAIRS; k++) begin
        pair_sums[k] <= fir_pkg::pair_t'(taps[k])
                      + fir_pkg::pair_t'(taps[fir_pkg::NUM_TAPS-1-k]);
      end
      // center tap has no partner.
      pair_sums[fir_pkg::NUM_PAIRS] <= fir_pkg::pair_t'(taps[fir_pkg::NUM_PAIRS]);
    end
  end

endmodule

`default_nettype wire

//--- verilog/fir_pkg.sv
`default_nettype none

package fir_pkg;

  // filter geometry.
  localparam int NUM_TAPS  = 15;
  localparam int NUM_COEF  = 8;   // index 7 is the center tap.
  localparam int NUM_PAIRS = 7;   // mirrored taps folded by the pre-adder.

  // datapath widths, all unsigned.
  localparam int SAMPLE_W    = 20;
  localparam int COEF_W      = 16;
  localparam int PAIR_W      = 21;  // one carry bit above a sample.
  localparam int PROD_W      = 37;  // PAIR_W + COEF_W.
  localparam int ACC_W       = 40;  // eight products need three more bits.
  localparam int COEF_ADDR_W = 3;

  // cycles from in_valid to out_valid.
  // one for the shift, one for the pre-add, one each for product and sum.
  localparam int LATENCY = 3;

  typedef logic [SAMPLE_W-1:0]    sample_t;
  typedef logic [COEF_W-1:0]      coef_t;
  typedef logic [COEF_ADDR_W-1:0] coef_addr_t;

  // folded pair sum, or the center sample zero extended.
  typedef logic [PAIR_W-1:0]      pair_t;

  typedef logic [PROD_W-1:0]      prod_t;
  typedef logic [ACC_W-1:0]       acc_t;

endpackage

`default_nettype wire
